//--- build.f
common/tcdm_pkg.sv
hdl/stream_fifo.sv
tcdm_core_fifo/tcdm_core_fifo.sv
hdl/tcdm_access_gen.sv
hdl/tcdm_bank.sv
hdl/tcdm_subsys_top.sv
testbench/tb_checker.sv
testbench/tb_tcdm_subsys.sv

//--- Makefile
# Verilator build and run for the TCDM subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_tcdm_subsys.sv
// Testbench top with clock, reset, burst stimulus, reference memory model and timeout
`timescale 1ns/1ps

module tb_tcdm_subsys;
  import tcdm_pkg::*;

  localparam int unsigned N_RAND      = 12;                     // Random read bursts
  localparam int unsigned CMD_WORDS   = 64 + 1024 + 260 + N_RAND * 256 + 140 + 288;
  localparam int unsigned TIMEOUT_CYC = 40 * CMD_WORDS + 2000;

  logic              clk_i;
  logic              rst_ni;
  logic              clear_i;
  logic              start_i;
  logic              hold_i;
  acc_cmd_t          cmd_i;
  logic              busy_o;
  logic              done_o;
  logic              empty_o;
  logic [DATA_W-1:0] checksum_o;
  logic              idle_chk;
  logic              exp_read;
  logic [DATA_W-1:0] exp_sum;
  int unsigned       value_errs;
  int unsigned       protocol_errs;
  int unsigned       cycle_cnt = 0;
  int unsigned       hold_mode;                 // 0 released, 1 random, 2 stuck high
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];       // Expected bank contents

  tcdm_subsys_top uut (
    .clk_i, .rst_ni, .clear_i, .start_i, .cmd_i, .hold_i,
    .busy_o, .done_o, .checksum_o, .empty_o
  );

  tb_checker i_checker (
    .clk_i, .rst_ni, .start_i, .clear_i,
    .idle_chk_i      ( idle_chk      ),
    .exp_read_i      ( exp_read      ),
    .exp_sum_i       ( exp_sum       ),
    .busy_i          ( busy_o        ),
    .done_i          ( done_o        ),
    .empty_i         ( empty_o       ),
    .checksum_i      ( checksum_o    ),
    .value_errs_o    ( value_errs    ),
    .protocol_errs_o ( protocol_errs )
  );

  // Sum of the stored words over len plus one addresses, wrapping at the bank size
  function automatic logic [DATA_W-1:0] sum_range(input logic [ADDR_W-1:0] base,
                                                  input int unsigned len);
    logic [DATA_W-1:0] acc;
    logic [ADDR_W-1:0] a;
    acc = '0;
    for (int unsigned i = 0; i <= len; i++) begin
      a   = base + ADDR_W'(i);
      acc = acc + ref_mem[a];
    end
    return acc;
  endfunction

  // Raises start for one cycle when entered 1 ns after an edge
  task automatic issue_burst(input logic [ADDR_W-1:0] base, input int unsigned len,
                             input logic we, input logic [DATA_W-1:0] seed);
    logic [ADDR_W-1:0] a;
    if (we) begin
      for (int unsigned i = 0; i <= len; i++) begin
        a          = base + ADDR_W'(i);
        ref_mem[a] = seed + i;                  // Word i carries seed plus i
      end
    end
    cmd_i.base = base;
    cmd_i.len  = LEN_W'(len);
    cmd_i.we   = we;
    cmd_i.seed = seed;
    cmd_i.user = USER_W'($urandom);
    exp_read   = ~we;
    exp_sum    = we ? '0 : sum_range(base, len);
    start_i    = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
  endtask

  task automatic run_burst(input logic [ADDR_W-1:0] base, input int unsigned len,
                           input logic we, input logic [DATA_W-1:0] seed);
    issue_burst(base, len, we, seed);
    do @(posedge clk_i); while (!done_o);     // Waits for the done pulse of this burst
    #1;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Mode is sampled on the edge and applied 1 ns later
  initial begin
    int unsigned mode;
    hold_i = 1'b0;
    forever begin
      @(posedge clk_i);
      mode = hold_mode;
      #1;
      hold_i = (mode == 2) || ((mode == 1) && (($urandom % 4) != 0));
    end
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYC);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Verification failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h23e7_6f8a));
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    start_i   = 1'b0;
    cmd_i     = '0;
    idle_chk  = 1'b0;
    exp_read  = 1'b0;
    exp_sum   = '0;
    hold_mode = 0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    idle_chk = 1'b1;                            // Reset state before any command
    repeat (4) @(posedge clk_i);
    #1;
    idle_chk = 1'b0;
    run_burst(10'd40, 31, 1'b1, 32'h1000_0000);
    run_burst(10'd40, 31, 1'b0, '0);
    for (int q = 0; q < 4; q++) begin
      run_burst(ADDR_W'(q * 256), 255, 1'b1, $urandom);  // Whole bank gets written
    end
    run_burst(10'd0, 0, 1'b0, '0);
    run_burst(10'd1023, 0, 1'b0, '0);
    run_burst(10'd900, 255, 1'b0, '0);         // Wraps past the top address
    run_burst(10'd1023, 0, 1'b1, 32'hdead_0001);
    run_burst(10'd1023, 0, 1'b0, '0);
    hold_mode = 1;
    for (int r = 0; r < N_RAND; r++) begin
      run_burst(ADDR_W'($urandom % MEM_WORDS), $urandom % 256, 1'b0, '0);
    end
    hold_mode = 0;
    run_burst(10'd100, 39, 1'b1, 32'h5555_0000);
    run_burst(10'd120, 39, 1'b1, 32'haaaa_0000);  // Overlaps the last 20 words
    run_burst(10'd100, 59, 1'b0, '0);
    hold_mode = 2;
    issue_burst(10'd0, 255, 1'b0, '0);
    repeat (40) @(posedge clk_i);               // Both FIFOs fill behind the hold
    #1;
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i   = 1'b0;
    hold_mode = 0;
    repeat (FIFO_DEPTH + 3) @(posedge clk_i);
    #1;
    run_burst(10'd500, 15, 1'b1, 32'h0bad_c0de);
    run_burst(10'd500, 15, 1'b0, '0);
    repeat (20) @(posedge clk_i);               // Room for a stray done pulse
    $display("Errors: %0d value, %0d protocol", value_errs, protocol_errs);
    if (value_errs == 0 && protocol_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_checker.sv
// Testbench checker for burst checksums, done pulses, idle state and flush recovery
`timescale 1ns/1ps

module tb_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,     // Burst strobe as seen by the DUT
  input  logic                        clear_i,
  input  logic                        idle_chk_i,  // Expect the reset state while high
  input  logic                        exp_read_i,  // Burst being started is a read
  input  logic [tcdm_pkg::DATA_W-1:0] exp_sum_i,   // Reference checksum of that burst
  input  logic                        busy_i,
  input  logic                        done_i,
  input  logic                        empty_i,
  input  logic [tcdm_pkg::DATA_W-1:0] checksum_i,
  output int unsigned                 value_errs_o,
  output int unsigned                 protocol_errs_o
);
  import tcdm_pkg::*;

  logic              armed;            // A burst is running and owes one done pulse
  logic              read_burst;
  logic [DATA_W-1:0] exp_sum;          // Latched with the start strobe
  int unsigned       clr_wait;         // Cycles left for the flush to settle
  int unsigned       value_errs = 0;
  int unsigned       protocol_errs = 0;

  assign value_errs_o    = value_errs;
  assign protocol_errs_o = protocol_errs;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      armed    = 1'b0;
      clr_wait = 0;
    end else begin
      if (idle_chk_i && (busy_i || done_i || !empty_i || checksum_i != '0)) begin
        value_errs++;
        $display("CHECK FAILED at %0t: idle state busy=%b done=%b empty=%b checksum=0x%08h",
                 $time, busy_i, done_i, empty_i, checksum_i);
      end
      if (done_i) begin
        if (!armed) begin
          protocol_errs++;                 // A second pulse lands here too
          $display("Protocol error at %0t: done_o pulsed with no burst running", $time);
        end else if (checksum_i != exp_sum) begin
          value_errs++;
          $display("CHECK FAILED at %0t: %s burst checksum 0x%08h, expected 0x%08h",
                   $time, read_burst ? "read" : "write", checksum_i, exp_sum);
        end
        if (busy_i) begin
          protocol_errs++;
          $display("Protocol error at %0t: busy_o still high during done_o", $time);
        end
        armed = 1'b0;
      end
      if (clr_wait != 0) begin
        if (!busy_i && empty_i) begin
          clr_wait = 0;                    // Flush has settled in time
        end else if (clr_wait == 1) begin
          value_errs++;
          $display("CHECK FAILED at %0t: busy=%b empty=%b %0d cycles after clear",
                   $time, busy_i, empty_i, FIFO_DEPTH + 2);
          clr_wait = 0;
        end else begin
          clr_wait--;
        end
      end
      if (clear_i) begin
        armed    = 1'b0;                   // A flushed burst never reports done
        clr_wait = FIFO_DEPTH + 2;
      end else if (start_i) begin
        armed      = 1'b1;
        read_burst = exp_read_i;
        exp_sum    = exp_sum_i;            // Writes leave the restarted checksum at zero
      end
    end
  end

endmodule

//--- hdl/tcdm_subsys_top.sv
// Top level joining the access generator, the decoupling FIFO and the memory bank
`timescale 1ns/1ps

module tcdm_subsys_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,     // Synchronous flush level
  input  logic                        start_i,
  input  tcdm_pkg::acc_cmd_t          cmd_i,
  input  logic                        hold_i,      // Back-pressure on responses
  output logic                        busy_o,
  output logic                        done_o,
  output logic [tcdm_pkg::DATA_W-1:0] checksum_o,
  output logic                        empty_o      // Both FIFO directions empty
);
  import tcdm_pkg::*;

  tcdm_req_t gen_req;       // Generator to buffer
  logic      gen_valid;
  logic      gen_gnt;
  tcdm_rsp_t gen_rsp;
  logic      gen_rvalid;
  logic      gen_rready;
  tcdm_req_t bank_req;      // Buffer to bank
  logic      bank_valid;
  logic      bank_gnt;
  tcdm_rsp_t bank_rsp;
  logic      bank_rvalid;

  tcdm_access_gen i_gen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .start_i      ( start_i    ),
    .cmd_i        ( cmd_i      ),
    .hold_i       ( hold_i     ),
    .busy_o       ( busy_o     ),
    .done_o       ( done_o     ),
    .checksum_o   ( checksum_o ),
    .mem_req_o    ( gen_req    ),
    .mem_valid_o  ( gen_valid  ),
    .mem_gnt_i    ( gen_gnt    ),
    .mem_rsp_i    ( gen_rsp    ),
    .mem_rvalid_i ( gen_rvalid ),
    .mem_rready_o ( gen_rready )
  );

  tcdm_core_fifo i_fifo (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear_i     ),
    .tgt_req_i    ( gen_req     ),
    .tgt_valid_i  ( gen_valid   ),
    .tgt_gnt_o    ( gen_gnt     ),
    .tgt_rsp_o    ( gen_rsp     ),
    .tgt_rvalid_o ( gen_rvalid  ),
    .tgt_rready_i ( gen_rready  ),
    .ini_req_o    ( bank_req    ),
    .ini_valid_o  ( bank_valid  ),
    .ini_gnt_i    ( bank_gnt    ),
    .ini_rsp_i    ( bank_rsp    ),
    .ini_rvalid_i ( bank_rvalid ),
    .empty_o      ( empty_o     )
  );

  tcdm_bank i_bank (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .req_i    ( bank_req    ),
    .valid_i  ( bank_valid  ),
    .gnt_o    ( bank_gnt    ),
    .rsp_o    ( bank_rsp    ),
    .rvalid_o ( bank_rvalid )
  );

endmodule

//--- hdl/tcdm_bank.sv
// Single-port word memory with LFSR grant stalls and one-cycle read latency
`timescale 1ns/1ps

module tcdm_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::tcdm_req_t req_i,
  input  logic                valid_i,   // Request is offered
  output logic                gnt_o,
  output tcdm_pkg::tcdm_rsp_t rsp_o,     // Read data of the previous granted read
  output logic                rvalid_o
);
  import tcdm_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];  // Word storage without reset
  logic [15:0]       lfsr_q;             // Stall pattern source
  logic              stall;
  logic              rvalid_q;
  tcdm_rsp_t         rsp_q;

  // Galois LFSR with taps 16, 14, 13 and 11 for a maximal sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 16'hace1;                // Any nonzero seed works
    end else begin
      lfsr_q <= {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hb400 : 16'h0000);
    end
  end

  assign stall = (lfsr_q[1:0] == 2'b00); // Roughly one cycle in four
  assign gnt_o = valid_i & ~stall;       // Grant only a raised request

  always_ff @(posedge clk_i) begin
    if (gnt_o && req_i.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req_i.be[b]) begin
          mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];  // Byte lane write
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o && !req_i.we) begin
      rsp_q.rdata <= mem_q[req_i.addr];  // Registered read port
      rsp_q.ruser <= req_i.user;         // Tag travels with the data
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o & ~req_i.we;     // Only reads return a word
    end
  end

  assign rsp_o    = rsp_q;
  assign rvalid_o = rvalid_q;

endmodule

//--- hdl/tcdm_access_gen.sv
// Burst request generator with a running checksum of returned read data
`timescale 1ns/1ps

module tcdm_access_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,       // Back to idle with a zero checksum
  input  logic                  start_i,       // One-cycle strobe with cmd_i
  input  tcdm_pkg::acc_cmd_t    cmd_i,
  input  logic                  hold_i,        // Refuse responses while high
  output logic                  busy_o,
  output logic                  done_o,        // Pulse after the last counted event
  output logic [tcdm_pkg::DATA_W-1:0] checksum_o,
  output tcdm_pkg::tcdm_req_t   mem_req_o,
  output logic                  mem_valid_o,
  input  logic                  mem_gnt_i,
  input  tcdm_pkg::tcdm_rsp_t   mem_rsp_i,
  input  logic                  mem_rvalid_i,
  output logic                  mem_rready_o
);
  import tcdm_pkg::*;

  acc_cmd_t          cmd_q;       // Command of the running burst
  logic              busy_q;
  logic              done_q;
  logic              issued_q;    // Every request of the burst has transferred
  logic [LEN_W-1:0]  idx_q;       // Index of the word being offered
  logic [LEN_W-1:0]  rcnt_q;      // Responses accepted so far
  logic [DATA_W-1:0] checksum_q;
  logic              req_xfer;
  logic              rsp_xfer;
  logic              last_issue;
  logic              last_rsp;
  logic              finish;

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  assign checksum_o = checksum_q;

  // Word i goes to base plus i, which wraps at MEM_WORDS through the address width
  assign mem_req_o.addr  = cmd_q.base + ADDR_W'(idx_q);
  assign mem_req_o.wdata = cmd_q.seed + DATA_W'(idx_q);
  assign mem_req_o.be    = '1;                            // Full words only
  assign mem_req_o.we    = cmd_q.we;
  assign mem_req_o.user  = cmd_q.user;
  assign mem_valid_o     = busy_q & ~issued_q;            // Held until granted
  assign mem_rready_o    = busy_q & ~hold_i;

  assign req_xfer   = mem_valid_o & mem_gnt_i;
  assign rsp_xfer   = mem_rvalid_i & mem_rready_o;
  assign last_issue = (idx_q == cmd_q.len);
  assign last_rsp   = (rcnt_q == cmd_q.len);
  // Writes end on the last transfer, reads on the last accepted response
  assign finish     = busy_q & ((req_xfer & last_issue & cmd_q.we) |
                                (rsp_xfer & last_rsp & ~cmd_q.we));

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_q) begin
      cmd_q <= cmd_i;                                     // Captured once per burst
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      issued_q   <= 1'b0;
      idx_q      <= '0;
      rcnt_q     <= '0;
      checksum_q <= '0;
    end else if (clear_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      issued_q   <= 1'b0;
      idx_q      <= '0;
      rcnt_q     <= '0;
      checksum_q <= '0;
    end else begin
      done_q <= finish;                                   // Same cycle as busy falls
      if (start_i && !busy_q) begin
        busy_q     <= 1'b1;                               // First request offered next cycle
        issued_q   <= 1'b0;
        idx_q      <= '0;
        rcnt_q     <= '0;
        checksum_q <= '0;
      end else if (busy_q) begin
        if (req_xfer) begin
          if (last_issue) begin
            issued_q <= 1'b1;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
        if (rsp_xfer) begin
          checksum_q <= checksum_q + mem_rsp_i.rdata;     // Sum modulo 2 to the 32
          rcnt_q     <= rcnt_q + 1'b1;
        end
        if (finish) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // A new command only arrives once the previous burst has finished
  a_no_start_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_o);

  // Every response accepted belongs to the running burst
  a_rsp_user : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    rsp_xfer |-> (mem_rsp_i.ruser == cmd_q.user));

endmodule

//--- tcdm_core_fifo/tcdm_core_fifo.sv
// Two-direction request/response decoupling FIFO with a response skid register
`timescale 1ns/1ps

module tcdm_core_fifo (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,       // Flushes both queues and the skid register
  input  tcdm_pkg::tcdm_req_t tgt_req_i,     // Request word from the generator
  input  logic                tgt_valid_i,   // Generator req
  output logic                tgt_gnt_o,     // Request FIFO has room
  output tcdm_pkg::tcdm_rsp_t tgt_rsp_o,     // Response word towards the generator
  output logic                tgt_rvalid_o,
  input  logic                tgt_rready_i,  // External back-pressure on responses
  output tcdm_pkg::tcdm_req_t ini_req_o,     // Request word towards the bank
  output logic                ini_valid_o,   // Bank req
  input  logic                ini_gnt_i,
  input  tcdm_pkg::tcdm_rsp_t ini_rsp_i,     // Read data from the bank
  input  logic                ini_rvalid_i,  // Bank ignores ready, so this cannot stall
  output logic                empty_o
);
  import tcdm_pkg::*;

  fifo_flags_t      req_flags;
  fifo_flags_t      rsp_flags;
  logic [REQ_W-1:0] req_pop_data;
  logic             req_pop_valid;
  logic [RSP_W-1:0] rsp_pop_data;
  logic [RSP_W-1:0] rsp_push_data;
  logic             rsp_push_valid;
  logic             rsp_push_ready;
  logic             skid_valid_q;            // Skid register holds a response
  tcdm_rsp_t        skid_rsp_q;              // Response that could not be pushed
  logic             skid_load;

  // Outgoing direction with req and gnt mapped to push valid and ready
  stream_fifo #(
    .DATA_WIDTH ( REQ_W )
  ) i_req_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_data_i  ( tgt_req_i     ),
    .push_valid_i ( tgt_valid_i   ),
    .push_ready_o ( tgt_gnt_o     ),
    .pop_data_o   ( req_pop_data  ),
    .pop_valid_o  ( req_pop_valid ),
    .pop_ready_i  ( ini_gnt_i     ),  // Bank grants only a raised req
    .flags_o      ( req_flags     )
  );

  assign ini_req_o   = req_pop_data;
  // No request leaves unless its response has a slot, and none during a flush
  assign ini_valid_o = req_pop_valid & ~rsp_flags.full & ~clear_i;

  // A held response goes first, and a new arrival then waits in the skid slot
  assign rsp_push_valid = skid_valid_q | ini_rvalid_i;
  assign rsp_push_data  = skid_valid_q ? skid_rsp_q : ini_rsp_i;

  // Catch a new response that cannot enter the FIFO this cycle
  assign skid_load = ini_rvalid_i & (skid_valid_q | ~rsp_push_ready);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      skid_valid_q <= 1'b0;
    end else if (clear_i) begin
      skid_valid_q <= 1'b0;
    end else if (skid_load) begin
      skid_valid_q <= 1'b1;                  // Overwrites an unpushed entry like the reference
    end else if (rsp_push_ready) begin
      skid_valid_q <= 1'b0;                  // Held entry went into the FIFO
    end
  end

  always_ff @(posedge clk_i) begin
    if (skid_load) begin
      skid_rsp_q <= ini_rsp_i;
    end
  end

  // Incoming direction towards the generator
  stream_fifo #(
    .DATA_WIDTH ( RSP_W )
  ) i_rsp_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_data_i  ( rsp_push_data  ),
    .push_valid_i ( rsp_push_valid ),
    .push_ready_o ( rsp_push_ready ),
    .pop_data_o   ( rsp_pop_data   ),
    .pop_valid_o  ( tgt_rvalid_o   ),
    .pop_ready_i  ( tgt_rready_i   ),
    .flags_o      ( rsp_flags      )
  );

  assign tgt_rsp_o = rsp_pop_data;
  assign empty_o   = req_flags.empty & rsp_flags.empty;  // Both directions drained

  // The bank must never grant a request that this side did not raise
  a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ini_gnt_i |-> ini_valid_o);

endmodule

//--- hdl/stream_fifo.sv
// Generic valid/ready circular buffer FIFO with empty and full flags
`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,        // Synchronous flush of all entries
  input  logic [DATA_WIDTH-1:0] push_data_i,
  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  output logic [DATA_WIDTH-1:0] pop_data_o,
  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output tcdm_pkg::fifo_flags_t flags_o
);
  import tcdm_pkg::*;

  logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH];  // Entry storage
  logic [PTR_W-1:0]      wr_ptr_q;            // Next slot to write
  logic [PTR_W-1:0]      rd_ptr_q;            // Oldest stored slot
  logic [CNT_W-1:0]      count_q;             // Number of stored entries
  logic                  push;
  logic                  pop;

  assign flags_o.empty = (count_q == '0);
  assign flags_o.full  = (count_q == CNT_W'(FIFO_DEPTH));

  assign push_ready_o = ~flags_o.full;        // Room for one more word
  assign pop_valid_o  = ~flags_o.empty;       // Head entry is valid
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;  // Word enters this cycle
  assign pop  = pop_valid_o & pop_ready_i;    // Head leaves this cycle

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin               // Flush wins over any push or pop
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;            // Net gain of one entry
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;            // Net loss of one entry
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !clear_i) begin
      mem_q[wr_ptr_q] <= push_data_i;         // Storage is written only on an accepted push
    end
  end

  // Occupancy never goes past the depth
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(FIFO_DEPTH));

  // An empty FIFO can only gain one entry, so the count never wraps below zero
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q == '0) |=> (count_q <= CNT_W'(1)));

  // A stalled head word stays put until it is taken
  a_pop_stable : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (pop_valid_o && !pop_ready_i) |=> (pop_valid_o && $stable(pop_data_o)));

endmodule

//--- common/tcdm_pkg.sv
// Widths, depths, request and response words, burst command and FIFO flags
package tcdm_pkg;

  localparam int unsigned ADDR_W     = 10;                  // Word address into one bank
  localparam int unsigned DATA_W     = 32;                  // Bus and memory word width
  localparam int unsigned BE_W       = DATA_W / 8;          // One enable per byte lane
  localparam int unsigned USER_W     = 4;                   // Tag echoed back by the bank
  localparam int unsigned MEM_WORDS  = 1 << ADDR_W;         // Bank holds 1024 words
  localparam int unsigned FIFO_DEPTH = 8;                   // Entries in each direction
  localparam int unsigned LEN_W      = 8;                   // Burst length field, 0 means 1 word
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);  // Read and write pointer width
  localparam int unsigned CNT_W      = $clog2(FIFO_DEPTH + 1); // Occupancy must reach FIFO_DEPTH

  // Outgoing request, one word per transfer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // Word address
    logic [DATA_W-1:0] wdata;  // Only meaningful for writes
    logic [BE_W-1:0]   be;     // Byte enables for writes
    logic              we;     // High for a write, low for a read
    logic [USER_W-1:0] user;   // Returned with read data
  } tcdm_req_t;

  // Returning read word
  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // Read data
    logic [USER_W-1:0] ruser;  // Copy of the request user field
  } tcdm_rsp_t;

  // Burst command taken by the generator on start
  typedef struct packed {
    logic [ADDR_W-1:0] base;   // First word address
    logic [LEN_W-1:0]  len;    // Number of words minus one
    logic              we;     // Write burst when high
    logic [DATA_W-1:0] seed;   // Write data of word i is seed plus i
    logic [USER_W-1:0] user;   // Tag put on every request of the burst
  } acc_cmd_t;

  // Status of one FIFO
  typedef struct packed {
    logic empty;  // No entry stored
    logic full;   // FIFO_DEPTH entries stored
  } fifo_flags_t;

  localparam int unsigned REQ_W = $bits(tcdm_req_t);  // Width of the request FIFO
  localparam int unsigned RSP_W = $bits(tcdm_rsp_t);  // Width of the response FIFO

endpackage
